// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cam_capture_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	-$(SIM) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test passed$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/cam_capture_checker.sv ====
`timescale 1ns/1ps

module cam_capture_checker
(
  input logic cmos_pclk_i,
  input logic rst_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i
);

  // Failed assertions, read by the testbench at the end of the run
  int fail_count = 0;

  // Completion only inside an access phase
  ready_in_access: assert property (@(posedge cmos_pclk_i) disable iff (rst_i)
    $rose(pready_i) |-> (psel_i && penable_i))
  else
  begin
    fail_count++;
    $error("pready_o rose outside an APB access phase");
  end

  // Error response rides on the completion cycle
  err_with_ready: assert property (@(posedge cmos_pclk_i) disable iff (rst_i)
    pslverr_i |-> pready_i)
  else
  begin
    fail_count++;
    $error("pslverr_o high without pready_o");
  end

  // Fixed wait state, first penable cycle never completes
  wait_state: assert property (@(posedge cmos_pclk_i) disable iff (rst_i)
    (psel_i && $rose(penable_i)) |-> !pready_i)
  else
  begin
    fail_count++;
    $error("pready_o high in the first penable cycle");
  end

endmodule

bind cam_capture_top cam_capture_checker u_checker (
  .cmos_pclk_i (cmos_pclk_i),
  .rst_i       (rst_i),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .pslverr_i   (pslverr_o)
);

// ==== dv/cam_capture_tb.sv ====
`timescale 1ns/1ps

module cam_capture_tb;

  localparam int FRAME_W   = 16;
  localparam int FRAME_H   = 8;
  localparam int NPIX      = FRAME_W * FRAME_H;
  localparam int NPAIRS    = NPIX / 2;
  localparam int LINE_PRS  = FRAME_W / 2;
  // Two full frames, then one frame with an extra line
  localparam int NROWS     = 3 * NPAIRS + LINE_PRS;
  localparam int NFIXED    = 8;
  localparam int NFRAMES   = 4;
  localparam int FRAME_CYC = 4 * (NPAIRS + LINE_PRS) + 4 * (FRAME_H + 1) + 32;
  localparam int APB_CYC   = 6;
  localparam int WATCH_CYC = 2 * (NFRAMES * FRAME_CYC + APB_CYC * (3 * NPIX + 32));
  localparam int PRDY_MAX  = 16;

  logic        clk;
  logic        rst;
  logic        vsync;
  logic        href;
  logic [7:0]  data;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  // Stimulus table with one row per pixel pair and expected RGB per pixel
  logic [7:0]  tab_y0 [NROWS];
  logic [7:0]  tab_y1 [NROWS];
  logic [7:0]  tab_cb [NROWS];
  logic [7:0]  tab_cr [NROWS];
  logic [23:0] tab_p0 [NROWS];
  logic [23:0] tab_p1 [NROWS];
  int          seed;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  cam_capture_top #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) dut0 (
    .cmos_pclk_i  (clk),
    .rst_i        (rst),
    .cmos_vsync_i (vsync),
    .cmos_href_i  (href),
    .cmos_data_i  (data),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr)
  );

  // **********************************************************************
  // Reference model and stimulus table
  // **********************************************************************

  // Floor divide by 256, then saturate
  function automatic logic [7:0] clamp_byte(input int acc);
    int q;
    q = acc >>> 8;
    if (q < 0)
      return 8'd0;
    if (q > 255)
      return 8'd255;
    return q[7:0];
  endfunction

  function automatic logic [23:0] expect_rgb(input int y, input int cb, input int cr);
    int cbc;
    int crc;
    cbc = cb - 128;
    crc = cr - 128;
    return {clamp_byte(256 * y + 359 * crc),
            clamp_byte(256 * y - 88 * cbc - 183 * crc),
            clamp_byte(256 * y + 454 * cbc)};
  endfunction

  task automatic set_row(input int i, input logic [7:0] y0, input logic [7:0] y1,
                         input logic [7:0] cb, input logic [7:0] cr);
    tab_y0[i] = y0;
    tab_y1[i] = y1;
    tab_cb[i] = cb;
    tab_cr[i] = cr;
    tab_p0[i] = expect_rgb(y0, cb, cr);
    tab_p1[i] = expect_rgb(y1, cb, cr);
  endtask

  task automatic build_table();
    int          i;
    logic [31:0] r;
    // Columns Y0, Y1, Cb, Cr
    set_row(0, 8'd128, 8'd128, 8'd128, 8'd128);
    set_row(1, 8'd76, 8'd82, 8'd85, 8'd255);
    set_row(2, 8'd150, 8'd145, 8'd44, 8'd21);
    set_row(3, 8'd29, 8'd41, 8'd255, 8'd107);
    // R and B clip high
    set_row(4, 8'd255, 8'd255, 8'd255, 8'd255);
    // R and B clip low
    set_row(5, 8'd0, 8'd0, 8'd0, 8'd0);
    set_row(6, 8'd0, 8'd255, 8'd255, 8'd255);  // G below 0
    set_row(7, 8'd255, 8'd0, 8'd0, 8'd0);      // G above 255
    for (i = NFIXED; i < NROWS; i++)
    begin
      r = $random(seed);
      set_row(i, r[7:0], r[15:8], r[23:16], r[31:24]);
    end
  endtask

  // **********************************************************************
  // Sensor driver
  // **********************************************************************

  task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    href <= 1'b1;
    data <= b;
  endtask

  task automatic line_gap();
    @(posedge clk);
    href <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  // Sends table rows from first_row on with FRAME_W pixels per href burst
  task automatic send_frame(input int first_row, input int n_pairs);
    int k;
    int row;
    @(posedge clk);
    vsync <= 1'b0;
    repeat (4) @(posedge clk);
    for (k = 0; k < n_pairs; k++)
    begin
      row = first_row + k;
      send_byte(tab_cb[row]);
      send_byte(tab_y0[row]);
      send_byte(tab_cr[row]);
      send_byte(tab_y1[row]);
      if ((k + 1) % LINE_PRS == 0 || k == n_pairs - 1)
        line_gap();
    end
    @(posedge clk);
    vsync <= 1'b1;
    // Pipeline drains within 8 cycles of the vsync rise
    repeat (12) @(posedge clk);
  endtask

  // **********************************************************************
  // APB master and checks
  // **********************************************************************

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Setup and access phases with outputs sampled on the falling edge
  task automatic apb_access(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!pready && n < PRDY_MAX)
    begin
      @(negedge clk);
      n++;
    end
    if (!pready)
    begin
      $display("APB access to %h got no pready_o within %0d cycles", addr, PRDY_MAX);
      $display("Test failed");
      $fatal(1, "APB handshake timeout");
    end
    else
    begin
      // Exactly one wait state per access
      check_value("pready_o wait states", 32'(n), 32'd1);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic reg_read(input logic [11:0] addr, input logic [31:0] exp_data,
                          input logic exp_err, input string what);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rd, err);
    check_value($sformatf("prdata_o (%s)", what), rd, exp_data);
    check_value($sformatf("pslverr_o (%s)", what), 32'(err), 32'(exp_err));
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] wdata,
                           input logic exp_err, input string what);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_value($sformatf("pslverr_o (%s)", what), 32'(err), 32'(exp_err));
  endtask

  // Pixel n comes from row n/2 and even n is the Y0 pixel
  task automatic check_window(input int first_row, input string what);
    int          n;
    int          row;
    logic [23:0] exp;
    for (n = 0; n < NPIX; n++)
    begin
      row = first_row + n / 2;
      exp = (n % 2 == 0) ? tab_p0[row] : tab_p1[row];
      reg_read(cam_pkg::PIX_BASE + 12'(4 * n), {8'h00, exp}, 1'b0,
               $sformatf("%s pixel %0d", what, n));
    end
  endtask

  // **********************************************************************
  // Test sequence and watchdog
  // **********************************************************************

  initial
  begin
    repeat (WATCH_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCH_CYC);
    $display("Test failed");
    $fatal(1, "watchdog timeout");
  end

  // Any failed protocol assertion ends the run
  always @(negedge clk)
  begin
    if (dut0.u_checker.fail_count != 0)
    begin
      $display("An APB protocol assertion in the checker failed");
      $display("Test failed");
      $fatal(1, "protocol assertion failure");
    end
  end

  initial
  begin
    seed    = 32'h625733ef;
    rst     = 1'b1;
    vsync   = 1'b1;
    href    = 1'b0;
    data    = 8'h00;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 12'h000;
    pwdata  = 32'h0;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    reg_read(cam_pkg::CTRL_OFS, 32'h0, 1'b0, "CTRL after reset");
    reg_read(cam_pkg::STATUS_OFS, 32'h0, 1'b0, "STATUS after reset");

    // Frame with capture off is not counted
    send_frame(0, NPAIRS);
    reg_read(cam_pkg::STATUS_OFS, 32'h0, 1'b0, "STATUS capture off");

    // First captured frame
    reg_write(cam_pkg::CTRL_OFS, 32'h1, 1'b0, "CTRL enable");
    reg_read(cam_pkg::CTRL_OFS, 32'h1, 1'b0, "CTRL enabled");
    send_frame(0, NPAIRS);
    reg_read(cam_pkg::STATUS_OFS, 32'h1, 1'b0, "STATUS frame 1");
    check_window(0, "frame 1");

    // Second frame overwrites the whole window
    send_frame(NPAIRS, NPAIRS);
    reg_read(cam_pkg::STATUS_OFS, 32'h2, 1'b0, "STATUS frame 2");
    check_window(NPAIRS, "frame 2");

    // Error responses
    reg_write(cam_pkg::PIX_BASE, 32'h00ffffff, 1'b1, "pixel window write");
    reg_read(12'h008, 32'h0, 1'b1, "unmapped read");
    reg_read(cam_pkg::PIX_BASE + 12'(4 * NPIX), 32'h0, 1'b1, "read past window");
    reg_write(12'h010, 32'h1, 1'b1, "unmapped write");
    reg_write(cam_pkg::STATUS_OFS, 32'h1234, 1'b0, "STATUS write");
    reg_read(cam_pkg::STATUS_OFS, 32'h2, 1'b0, "STATUS after write");
    reg_read(cam_pkg::CTRL_OFS, 32'h1, 1'b0, "CTRL after errors");
    reg_read(cam_pkg::PIX_BASE, {8'h00, tab_p0[NPAIRS]}, 1'b0, "pixel 0 after write");

    // Extra line is dropped and the frame counts once
    send_frame(2 * NPAIRS, NPAIRS + LINE_PRS);
    reg_read(cam_pkg::STATUS_OFS, 32'h3, 1'b0, "STATUS overlong frame");
    check_window(2 * NPAIRS, "overlong frame");

    if (dut0.u_checker.fail_count == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
    begin
      $display("%0d APB protocol assertions failed", dut0.u_checker.fail_count);
      $display("Test failed");
      $fatal(1, "protocol assertion failure");
    end
  end

endmodule

// ==== filelist.f ====
src/cam_pkg.sv
src/cam_byte_decoder.sv
src/ycbcr422_to_rgb.sv
src/frame_store.sv
src/cam_apb_regs.sv
src/cam_capture_top.sv
dv/cam_capture_checker.sv
dv/cam_capture_tb.sv

// ==== src/cam_apb_regs.sv ====
`timescale 1ns/1ps

module cam_apb_regs
#(
  parameter int FRAME_W = 16,
  parameter int FRAME_H = 8
)
(
  input  logic                       cmos_pclk_i,
  input  logic                       rst_i,
  // APB slave
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [cam_pkg::APB_AW-1:0] paddr_i,
  input  logic [cam_pkg::APB_DW-1:0] pwdata_i,
  output logic [cam_pkg::APB_DW-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Frame store side
  input  logic [cam_pkg::RGB_W-1:0]  rd_data_i,
  input  logic [cam_pkg::CNT_W-1:0]  frame_count_i,
  output logic [cam_pkg::APB_AW-1:0] rd_addr_o,
  output logic                       capture_en_o
);

  localparam int PIX_DEPTH = FRAME_W * FRAME_H;

  cam_pkg::apb_phase_e        state_q;
  cam_pkg::reg_sel_e          sel;
  logic                       capture_en_q;
  logic [cam_pkg::APB_AW-1:0] pix_ofs;
  logic [cam_pkg::APB_DW-1:0] rd_mux;
  logic                       err;

  // Word index in the window, valid from the setup cycle on
  assign pix_ofs   = paddr_i - cam_pkg::PIX_BASE;
  assign rd_addr_o = {2'b00, pix_ofs[cam_pkg::APB_AW-1:2]};

  assign capture_en_o = capture_en_q;

  // Address decode
  always_comb
  begin
    sel = cam_pkg::NONE;
    if (paddr_i == cam_pkg::CTRL_OFS)
      sel = cam_pkg::CTRL;
    else if (paddr_i == cam_pkg::STATUS_OFS)
      sel = cam_pkg::STATUS;
    else if (paddr_i >= cam_pkg::PIX_BASE && paddr_i[1:0] == 2'b00 &&
             int'(rd_addr_o) < PIX_DEPTH)
      sel = cam_pkg::PIXEL;
  end

  // Read data, unmapped gives 0
  always_comb
  begin
    case (sel)
      cam_pkg::CTRL:   rd_mux = {{(cam_pkg::APB_DW-1){1'b0}}, capture_en_q};
      cam_pkg::STATUS: rd_mux = {{(cam_pkg::APB_DW-cam_pkg::CNT_W){1'b0}}, frame_count_i};
      cam_pkg::PIXEL:  rd_mux = {{(cam_pkg::APB_DW-cam_pkg::RGB_W){1'b0}}, rd_data_i};
      default:         rd_mux = '0;
    endcase
  end

  // Pixel window is read-only, STATUS writes drop silently
  assign err = (sel == cam_pkg::NONE) | ((sel == cam_pkg::PIXEL) & pwrite_i);

  // **********************************************************************
  // Phase FSM, one wait state on every access
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    if (rst_i)
    begin
      state_q      <= cam_pkg::IDLE;
      pready_o     <= 1'b0;
      pslverr_o    <= 1'b0;
      prdata_o     <= '0;
      capture_en_q <= 1'b0;
    end
    else
    begin
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      case (state_q)
        // Setup seen, first penable cycle comes next
        cam_pkg::IDLE:
        begin
          if (psel_i && !penable_i)
            state_q <= cam_pkg::ACCESS;
        end
        // Frame store data arrived, complete on the next cycle
        cam_pkg::ACCESS:
        begin
          if (psel_i && penable_i)
          begin
            state_q   <= cam_pkg::WAIT;
            pready_o  <= 1'b1;
            pslverr_o <= err;
            prdata_o  <= pwrite_i ? '0 : rd_mux;
            if (pwrite_i && sel == cam_pkg::CTRL)
              capture_en_q <= pwdata_i[0];
          end
          else
          begin
            state_q <= cam_pkg::IDLE;
          end
        end
        // pready high this cycle
        default:
        begin
          state_q <= cam_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== src/cam_byte_decoder.sv ====
`timescale 1ns/1ps

module cam_byte_decoder
(
  input  logic                     cmos_pclk_i,
  input  logic                     rst_i,
  // Sensor side
  input  logic                     cmos_vsync_i,
  input  logic                     cmos_href_i,
  input  logic [cam_pkg::PIX_W-1:0] cmos_data_i,
  // Decoded words, {chroma, luma}
  output logic                     yc_valid_o,
  output logic [cam_pkg::YC_W-1:0]  yc_data_o,
  // Frame markers
  output logic                     frame_start_o,
  output logic                     frame_end_o
);

  // Previous vsync level
  logic                      vsync_q;
  // High when the next byte completes a word
  logic                      byte_ph_q;
  // Chroma byte of the word in progress
  logic [cam_pkg::PIX_W-1:0] first_q;
  logic                      vs_fall;
  logic                      vs_rise;

  // Vsync low is active video
  assign vs_fall = vsync_q & ~cmos_vsync_i;
  assign vs_rise = ~vsync_q & cmos_vsync_i;

  // **********************************************************************
  // Control and frame edges
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    if (rst_i)
    begin
      vsync_q       <= 1'b0;
      byte_ph_q     <= 1'b0;
      yc_valid_o    <= 1'b0;
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
    end
    else
    begin
      vsync_q       <= cmos_vsync_i;
      frame_start_o <= vs_fall;
      frame_end_o   <= vs_rise;
      // Word out after the second byte
      yc_valid_o    <= cmos_href_i & byte_ph_q;
      // Href low realigns to Cb/Cr, so every burst starts on a chroma byte
      if (vs_fall || !cmos_href_i)
      begin
        byte_ph_q <= 1'b0;
      end
      else
      begin
        byte_ph_q <= ~byte_ph_q;
      end
    end
  end

  // **********************************************************************
  // Byte pairing
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    // Hold Cb or Cr
    if (cmos_href_i && !byte_ph_q)
    begin
      first_q <= cmos_data_i;
    end
    // Luma completes the word
    if (cmos_href_i && byte_ph_q)
    begin
      yc_data_o <= {first_q, cmos_data_i};
    end
  end

endmodule

// ==== src/cam_capture_top.sv ====
`timescale 1ns/1ps

module cam_capture_top
#(
  parameter int FRAME_W = 16,
  parameter int FRAME_H = 8
)
(
  // Sensor port
  input  logic                       cmos_pclk_i,
  input  logic                       rst_i,
  input  logic                       cmos_vsync_i,
  input  logic                       cmos_href_i,
  input  logic [cam_pkg::PIX_W-1:0]  cmos_data_i,
  // APB slave port, same clock
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [cam_pkg::APB_AW-1:0] paddr_i,
  input  logic [cam_pkg::APB_DW-1:0] pwdata_i,
  output logic [cam_pkg::APB_DW-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o
);

  // Decoder to converter
  logic                       yc_valid;
  logic [cam_pkg::YC_W-1:0]   yc_data;
  logic                       dec_frame_start;
  logic                       dec_frame_end;
  // Converter to frame store
  logic                       pix_valid;
  logic [cam_pkg::RGB_W-1:0]  pix_rgb;
  logic                       pix_frame_start;
  logic                       pix_frame_end;
  // Frame store and APB slave
  logic [cam_pkg::APB_AW-1:0] rd_addr;
  logic [cam_pkg::RGB_W-1:0]  rd_data;
  logic [cam_pkg::CNT_W-1:0]  frame_count;
  logic                       capture_en;

  // **********************************************************************
  // Capture pipeline, bytes to stored RGB
  // **********************************************************************

  cam_byte_decoder u_byte_decoder (
    .cmos_pclk_i   (cmos_pclk_i),
    .rst_i         (rst_i),
    .cmos_vsync_i  (cmos_vsync_i),
    .cmos_href_i   (cmos_href_i),
    .cmos_data_i   (cmos_data_i),
    .yc_valid_o    (yc_valid),
    .yc_data_o     (yc_data),
    .frame_start_o (dec_frame_start),
    .frame_end_o   (dec_frame_end)
  );

  ycbcr422_to_rgb u_ycbcr_to_rgb (
    .cmos_pclk_i   (cmos_pclk_i),
    .rst_i         (rst_i),
    .yc_valid_i    (yc_valid),
    .yc_data_i     (yc_data),
    .frame_start_i (dec_frame_start),
    .frame_end_i   (dec_frame_end),
    .pix_valid_o   (pix_valid),
    .pix_rgb_o     (pix_rgb),
    .frame_start_o (pix_frame_start),
    .frame_end_o   (pix_frame_end)
  );

  frame_store #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) u_frame_store (
    .cmos_pclk_i   (cmos_pclk_i),
    .rst_i         (rst_i),
    .pix_valid_i   (pix_valid),
    .pix_rgb_i     (pix_rgb),
    .frame_start_i (pix_frame_start),
    .frame_end_i   (pix_frame_end),
    .capture_en_i  (capture_en),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .frame_count_o (frame_count)
  );

  // Host registers and pixel readout
  cam_apb_regs #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) u_apb_regs (
    .cmos_pclk_i   (cmos_pclk_i),
    .rst_i         (rst_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .rd_data_i     (rd_data),
    .frame_count_i (frame_count),
    .rd_addr_o     (rd_addr),
    .capture_en_o  (capture_en)
  );

endmodule

// ==== src/cam_pkg.sv ====
package cam_pkg;

  // **********************************************************************
  // Data path widths
  // **********************************************************************

  // One sensor byte per pclk
  localparam int PIX_W  = 8;
  // Decoded word {chroma, luma}
  localparam int YC_W   = 16;
  // Stored pixel {r, g, b}
  localparam int RGB_W  = 24;
  // Captured frame counter
  localparam int CNT_W  = 16;

  // APB bus
  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  // **********************************************************************
  // Register map, byte offsets
  // **********************************************************************

  localparam logic [APB_AW-1:0] CTRL_OFS   = 12'h000;
  localparam logic [APB_AW-1:0] STATUS_OFS = 12'h004;
  // Pixel window runs to the top of the space, 768 words
  localparam logic [APB_AW-1:0] PIX_BASE   = 12'h400;

  // **********************************************************************
  // YCbCr to RGB, coefficients scaled by 256
  // **********************************************************************

  // 1.402 Cr
  localparam int COEF_R_CR  = 359;
  // 0.344 Cb and 0.714 Cr
  localparam int COEF_G_CB  = 88;
  localparam int COEF_G_CR  = 183;
  // 1.772 Cb
  localparam int COEF_B_CB  = 454;
  localparam int COEF_SHIFT = 8;
  // Chroma zero level
  localparam int CHROMA_OFS = 128;

  // APB slave phase
  typedef enum logic [1:0] {IDLE, ACCESS, WAIT} apb_phase_e;

  // Target of the current address
  typedef enum logic [1:0] {CTRL, STATUS, PIXEL, NONE} reg_sel_e;

endpackage

// ==== src/frame_store.sv ====
`timescale 1ns/1ps

module frame_store
#(
  parameter int FRAME_W = 16,
  parameter int FRAME_H = 8
)
(
  input  logic                       cmos_pclk_i,
  input  logic                       rst_i,
  // Pixel stream, in order with its frame markers
  input  logic                       pix_valid_i,
  input  logic [cam_pkg::RGB_W-1:0]  pix_rgb_i,
  input  logic                       frame_start_i,
  input  logic                       frame_end_i,
  input  logic                       capture_en_i,
  // Host read port, pixel index
  input  logic [cam_pkg::APB_AW-1:0] rd_addr_i,
  output logic [cam_pkg::RGB_W-1:0]  rd_data_o,
  output logic [cam_pkg::CNT_W-1:0]  frame_count_o
);

  localparam int PIX_DEPTH = FRAME_W * FRAME_H;
  localparam int ADDR_W    = (PIX_DEPTH > 1) ? $clog2(PIX_DEPTH) : 1;

  // Current frame is being captured
  logic                       cap_q;
  logic [cam_pkg::APB_AW-1:0] wr_addr_q;
  logic [cam_pkg::CNT_W-1:0]  frame_cnt_q;
  logic                       wr_en;
  logic [cam_pkg::RGB_W-1:0]  mem [PIX_DEPTH];

  // Overlong frames stop at the last word
  assign wr_en = pix_valid_i & cap_q & (int'(wr_addr_q) < PIX_DEPTH);

  assign frame_count_o = frame_cnt_q;

  // **********************************************************************
  // Capture gate, write address, frame counter
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    if (rst_i)
    begin
      cap_q       <= 1'b0;
      wr_addr_q   <= '0;
      frame_cnt_q <= '0;
    end
    else
    begin
      // Enable is sampled once per frame
      if (frame_start_i)
      begin
        cap_q     <= capture_en_i;
        wr_addr_q <= '0;
      end
      else if (wr_en)
      begin
        wr_addr_q <= wr_addr_q + 1'b1;
      end
      // Close the frame, count it if it was captured
      if (frame_end_i)
      begin
        cap_q <= 1'b0;
        if (cap_q)
          frame_cnt_q <= frame_cnt_q + 1'b1;
      end
    end
  end

  // **********************************************************************
  // Pixel memory, write from the pipeline and registered host read
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    if (wr_en)
    begin
      mem[wr_addr_q[ADDR_W-1:0]] <= pix_rgb_i;
    end
    rd_data_o <= mem[rd_addr_i[ADDR_W-1:0]];
  end

endmodule

// ==== src/ycbcr422_to_rgb.sv ====
`timescale 1ns/1ps

module ycbcr422_to_rgb
(
  input  logic                      cmos_pclk_i,
  input  logic                      rst_i,
  // Words alternate {Cb, Y0} and {Cr, Y1}
  input  logic                      yc_valid_i,
  input  logic [cam_pkg::YC_W-1:0]  yc_data_i,
  input  logic                      frame_start_i,
  input  logic                      frame_end_i,
  // One RGB888 pixel per valid cycle
  output logic                      pix_valid_o,
  output logic [cam_pkg::RGB_W-1:0] pix_rgb_o,
  output logic                      frame_start_o,
  output logic                      frame_end_o
);

  // Wide enough for 256*255 + 454*127
  localparam int MUL_W     = 20;
  // Pair complete to second pixel out
  localparam int PULSE_DLY = 4;

  logic                              word_ph_q;
  logic [cam_pkg::PIX_W-1:0]         cb_q;
  logic [cam_pkg::PIX_W-1:0]         y0_q;
  logic [cam_pkg::PIX_W-1:0]         in_chroma;
  logic [cam_pkg::PIX_W-1:0]         in_luma;
  logic                              pair_fire;
  logic signed [MUL_W-1:0]           cb_c;
  logic signed [MUL_W-1:0]           cr_c;
  // Stage 1, products
  logic                              s1_valid_q;
  logic signed [MUL_W-1:0]           s1_y0_q;
  logic signed [MUL_W-1:0]           s1_y1_q;
  logic signed [MUL_W-1:0]           s1_r_q;
  logic signed [MUL_W-1:0]           s1_gb_q;
  logic signed [MUL_W-1:0]           s1_gr_q;
  logic signed [MUL_W-1:0]           s1_b_q;
  // Stage 2, channel sums per pixel
  logic                              s2_valid_q;
  logic signed [MUL_W-1:0]           s2_r0_q;
  logic signed [MUL_W-1:0]           s2_g0_q;
  logic signed [MUL_W-1:0]           s2_b0_q;
  logic signed [MUL_W-1:0]           s2_r1_q;
  logic signed [MUL_W-1:0]           s2_g1_q;
  logic signed [MUL_W-1:0]           s2_b1_q;
  // Second pixel waiting one cycle
  logic                              pix1_pend_q;
  logic [cam_pkg::RGB_W-1:0]         pix1_q;
  logic [PULSE_DLY-1:0]              start_dly_q;
  logic [PULSE_DLY-1:0]              end_dly_q;

  // Floor shift by 256, then saturate to a byte
  function automatic logic [7:0] clamp8(input logic signed [MUL_W-1:0] v);
    logic signed [MUL_W-1:0] s;
    s = v >>> cam_pkg::COEF_SHIFT;
    if (s < 0)
      return 8'd0;
    else if (s > 255)
      return 8'd255;
    return s[7:0];
  endfunction

  assign in_chroma = yc_data_i[cam_pkg::YC_W-1:cam_pkg::PIX_W];
  assign in_luma   = yc_data_i[cam_pkg::PIX_W-1:0];
  // Cr/Y1 word closes the pair
  assign pair_fire = yc_valid_i & word_ph_q;
  // Centered chroma, -128..127
  assign cb_c = MUL_W'(cb_q) - MUL_W'(cam_pkg::CHROMA_OFS);
  assign cr_c = MUL_W'(in_chroma) - MUL_W'(cam_pkg::CHROMA_OFS);

  assign frame_start_o = start_dly_q[PULSE_DLY-1];
  assign frame_end_o   = end_dly_q[PULSE_DLY-1];

  // **********************************************************************
  // Control: word phase, stage valids, frame pulse delay
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    if (rst_i)
    begin
      word_ph_q   <= 1'b0;
      s1_valid_q  <= 1'b0;
      s2_valid_q  <= 1'b0;
      pix_valid_o <= 1'b0;
      pix1_pend_q <= 1'b0;
      start_dly_q <= '0;
      end_dly_q   <= '0;
    end
    else
    begin
      if (frame_start_i)
        word_ph_q <= 1'b0;
      else if (yc_valid_i)
        word_ph_q <= ~word_ph_q;
      s1_valid_q  <= pair_fire;
      s2_valid_q  <= s1_valid_q;
      // Pixel 0 then pixel 1 on the next cycle
      pix_valid_o <= s2_valid_q | pix1_pend_q;
      pix1_pend_q <= s2_valid_q;
      start_dly_q <= {start_dly_q[PULSE_DLY-2:0], frame_start_i};
      end_dly_q   <= {end_dly_q[PULSE_DLY-2:0], frame_end_i};
    end
  end

  // **********************************************************************
  // Payload: multiply, add, clamp
  // **********************************************************************

  always_ff @(posedge cmos_pclk_i)
  begin
    if (yc_valid_i && !word_ph_q)
    begin
      cb_q <= in_chroma;
      y0_q <= in_luma;
    end
    if (pair_fire)
    begin
      s1_y0_q <= MUL_W'(y0_q) <<< cam_pkg::COEF_SHIFT;
      s1_y1_q <= MUL_W'(in_luma) <<< cam_pkg::COEF_SHIFT;
      s1_r_q  <= cr_c * MUL_W'(cam_pkg::COEF_R_CR);
      s1_gb_q <= cb_c * MUL_W'(cam_pkg::COEF_G_CB);
      s1_gr_q <= cr_c * MUL_W'(cam_pkg::COEF_G_CR);
      s1_b_q  <= cb_c * MUL_W'(cam_pkg::COEF_B_CB);
    end
    // Both pixels share the pair's chroma terms
    s2_r0_q <= s1_y0_q + s1_r_q;
    s2_g0_q <= s1_y0_q - s1_gb_q - s1_gr_q;
    s2_b0_q <= s1_y0_q + s1_b_q;
    s2_r1_q <= s1_y1_q + s1_r_q;
    s2_g1_q <= s1_y1_q - s1_gb_q - s1_gr_q;
    s2_b1_q <= s1_y1_q + s1_b_q;
    if (s2_valid_q)
    begin
      pix_rgb_o <= {clamp8(s2_r0_q), clamp8(s2_g0_q), clamp8(s2_b0_q)};
      pix1_q    <= {clamp8(s2_r1_q), clamp8(s2_g1_q), clamp8(s2_b1_q)};
    end
    else if (pix1_pend_q)
    begin
      pix_rgb_o <= pix1_q;
    end
  end

endmodule
